//--- design/bus_settings.svh
// sizes and address constants for the cpu address path
// word addresses only, byte address bit n sits at word address bit n-1
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

`define BUS_ADDR_W      23      // cpu address bits 23..1
`define BUS_BANKS       8       // one-hot ram banks
`define BUS_OFFSET_W    18      // word offset inside a 512 KB block
`define BUS_REQ_DEPTH   4       // input fifo depth, also sender credits
`define BUS_LINK_DEPTH  2       // decode to map fifo depth
`define BUS_RSP_CREDITS 2       // output credits after reset
`define BUS_RTC_W       64      // rtc input, 16 nibbles

// region match patterns, top word address bits
`define BUS_SLOW_HI     3'b110  // c00000..dfffff, byte bits 23..21
`define BUS_RTC_PAGE    8'hdc   // byte bits 23..16
`define BUS_CIA_PAGE    8'hbf   // byte bits 23..16
`define BUS_CUSTOM_PAGE 12'hdff // byte bits 23..12
`define BUS_KICK_HI     5'h1f   // f80000..ffffff, byte bits 23..19

`endif

//--- design/bus_pkg.sv
// shared types of the address path, widths come from the settings header
`include "bus_settings.svh"
`default_nettype none

package bus_pkg;

	// region codes, zero is the miss case
	typedef enum logic [2:0] {
		region_none   = 3'd0,
		region_chip   = 3'd1,
		region_slow   = 3'd2,
		region_kick   = 3'd3,
		region_cia_a  = 3'd4,
		region_cia_b  = 3'd5,
		region_custom = 3'd6,
		region_rtc    = 3'd7
	} region_t;

	// memory size setting, static outside reset
	typedef struct packed {
		logic [1:0] chip_blocks;   // enabled chip blocks minus one
		logic [1:0] slow_blocks;   // 0..3 slow blocks
	} mem_cfg_t;

	// raw cpu request
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;   // word address
		logic                   write;
		logic [1:0]             be;     // upper, lower byte
	} bus_req_t;

	// request after region decode
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic                   write;
		region_t                region;
		logic [1:0]             block;  // block inside the region
	} decoded_t;

	// mapped response
	typedef struct packed {
		region_t                  region;
		logic [`BUS_BANKS-1:0]    bank;    // one-hot, zero off memory
		logic [`BUS_OFFSET_W-1:0] offset;
		logic                     write;
		logic [3:0]               rdata;   // rtc nibble on rtc reads
	} bus_rsp_t;

endpackage

`default_nettype wire

//--- design/credit_fifo.sv
// in-order fifo, the sender must hold a credit per push
// a push seen full is dropped, so the credit loop has to stay intact
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic in_valid,   // push
	input  payload_t  in_data,
	output logic      out_valid,  // head entry present
	output payload_t  out_data,
	input  wire logic pop,
	output logic      credit      // one pulse per popped entry
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t        mem [DEPTH];
	logic [PW-1:0]   wr_ptr;
	logic [PW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic            do_push;
	logic            do_pop;

	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];       // head read, no output register
	assign do_push   = in_valid && (count != CW'(DEPTH));
	assign do_pop    = pop && out_valid;

	//--------------------------------------------------------------------
	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	//--------------------------------------------------------------------
	// pointers, occupancy and credit return
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			credit <= do_pop;  // returned the cycle after the pop
			if (do_push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/addr_decode_stage.sv
// region decode of the popped request, combinational
// overlay maps low reads to kickstart until the first cia_a write
`include "bus_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module addr_decode_stage (
	input  wire logic         clk,
	input  wire logic         rst_n,
	input  wire logic         in_valid,
	input  bus_pkg::bus_req_t in_req,
	output logic              pop,
	input  bus_pkg::mem_cfg_t mem_cfg,
	output logic              out_valid,
	output bus_pkg::decoded_t out_dec,
	input  wire logic         credit_in   // from link fifo
);

	localparam int CW = $clog2(`BUS_LINK_DEPTH + 1);

	logic [CW-1:0]        credits;   // free link fifo slots
	logic                 ovl;       // kickstart overlay
	bus_pkg::region_t     region;
	logic [1:0]           block;
	logic [`BUS_ADDR_W-1:0] a;

	assign a         = in_req.addr;
	assign pop       = in_valid && (credits != '0);
	assign out_valid = pop;

	//--------------------------------------------------------------------
	// address decode
	always_comb begin
		region = bus_pkg::region_none;
		block  = a[19:18];                       // byte bits 20..19
		if (ovl && !in_req.write && a[22:18] == 5'h00) begin
			region = bus_pkg::region_kick;       // overlay below 080000
		end else if (a[22:20] == 3'b000) begin   // chip 000000..1fffff
			if (block <= mem_cfg.chip_blocks) begin
				region = bus_pkg::region_chip;
			end
		end else if (a[22:15] == `BUS_RTC_PAGE) begin
			region = bus_pkg::region_rtc;
		end else if (a[22:11] == `BUS_CUSTOM_PAGE) begin
			region = bus_pkg::region_custom;
		end else if (a[22:15] == `BUS_CIA_PAGE) begin
			if (!a[11]) begin                    // byte bit 12
				region = bus_pkg::region_cia_a;
			end else if (!a[12]) begin           // byte bit 13
				region = bus_pkg::region_cia_b;
			end
		end else if (a[22:18] == `BUS_KICK_HI) begin
			region = bus_pkg::region_kick;
		end else if (a[22:20] == `BUS_SLOW_HI) begin
			// d80000 and up never passes, slow_blocks tops out at 3
			if (block < mem_cfg.slow_blocks) begin
				region = bus_pkg::region_slow;
			end
		end
		if (region != bus_pkg::region_chip && region != bus_pkg::region_slow) begin
			block = 2'd0;                        // single block regions
		end
	end

	assign out_dec.addr   = in_req.addr;
	assign out_dec.write  = in_req.write;
	assign out_dec.region = region;
	assign out_dec.block  = block;

	//--------------------------------------------------------------------
	// link credits and overlay flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CW'(`BUS_LINK_DEPTH);
			ovl     <= 1'b1;
		end else begin
			case ({pop, credit_in})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			// any byte strobe counts, as on the cpu bus
			if (pop && region == bus_pkg::region_cia_a && in_req.write && |in_req.be) begin
				ovl <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/bank_map_stage.sv
// bank mapping and rtc readout, one register stage to the output
// rsp_valid is only raised against a held output credit
`include "bus_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module bank_map_stage (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  in_valid,
	input  bus_pkg::decoded_t          in_dec,
	output logic                       pop,
	input  wire logic [`BUS_RTC_W-1:0] rtc,
	output logic                       rsp_valid,
	output bus_pkg::bus_rsp_t          rsp,
	input  wire logic                  rsp_credit   // consumer frees one
);

	localparam int CW = $clog2(`BUS_RSP_CREDITS + 1);

	logic [CW-1:0]         credits;
	logic [`BUS_BANKS-1:0] bank;
	logic [3:0]            nibble;
	bus_pkg::bus_rsp_t     mapped;

	assign pop = in_valid && (credits != '0);

	//--------------------------------------------------------------------
	// region and block to one-hot bank
	always_comb begin
		case (in_dec.region)
			bus_pkg::region_chip: bank = `BUS_BANKS'(1) << in_dec.block;         // bits 0..3
			bus_pkg::region_slow: bank = `BUS_BANKS'(1) << (3'd4 + in_dec.block);  // bits 4..6
			bus_pkg::region_kick: bank = `BUS_BANKS'(1) << (`BUS_BANKS - 1);     // top bank
			default:              bank = '0;  // registers, rtc, misses
		endcase
	end

	// nibble k sits at byte address dc0000 + 4k
	assign nibble = rtc[{in_dec.addr[4:1], 2'b00} +: 4];

	assign mapped.region = in_dec.region;
	assign mapped.bank   = bank;
	assign mapped.offset = in_dec.addr[`BUS_OFFSET_W-1:0];  // byte bits 18..1
	assign mapped.write  = in_dec.write;
	assign mapped.rdata  = (in_dec.region == bus_pkg::region_rtc && !in_dec.write) ?
		nibble : 4'h0;

	//--------------------------------------------------------------------
	// output register, payload without reset
	always_ff @(posedge clk) begin
		if (pop) begin
			rsp <= mapped;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			credits   <= CW'(`BUS_RSP_CREDITS);
		end else begin
			rsp_valid <= pop;
			case ({pop, rsp_credit})
				2'b10:   credits <= credits - 1'b1;  // spent at launch
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/bus_map_top.sv
// cpu address path top, credit flow on both the request and response side
// mem_cfg must stay static while out of reset
`include "bus_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module bus_map_top (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	// request side
	input  wire logic                     req_valid,
	input  wire logic [`BUS_ADDR_W-1:0]   req_addr,    // word address
	input  wire logic                     req_write,
	input  wire logic [1:0]               req_be,
	output logic                          req_credit,
	// response side
	output logic                          rsp_valid,
	output bus_pkg::region_t              rsp_region,
	output logic [`BUS_BANKS-1:0]         rsp_bank,
	output logic [`BUS_OFFSET_W-1:0]      rsp_offset,
	output logic                          rsp_write,
	output logic [3:0]                    rsp_rdata,
	input  wire logic                     rsp_credit,
	// static inputs
	input  bus_pkg::mem_cfg_t             mem_cfg,
	input  wire logic [`BUS_RTC_W-1:0]    rtc
);

	bus_pkg::bus_req_t req_in;
	bus_pkg::bus_req_t req_head;
	bus_pkg::decoded_t dec;
	bus_pkg::decoded_t dec_head;
	bus_pkg::bus_rsp_t rsp;
	logic              req_head_valid;
	logic              req_pop;
	logic              dec_valid;
	logic              dec_head_valid;
	logic              dec_pop;
	logic              link_credit;

	assign req_in.addr  = req_addr;
	assign req_in.write = req_write;
	assign req_in.be    = req_be;

	//--------------------------------------------------------------------
	// input fifo, then decode, link fifo, map
	credit_fifo #(.payload_t(bus_pkg::bus_req_t), .DEPTH(`BUS_REQ_DEPTH)) req_fifo (
		.clk(clk), .rst_n(rst_n),
		.in_valid(req_valid), .in_data(req_in),
		.out_valid(req_head_valid), .out_data(req_head),
		.pop(req_pop), .credit(req_credit)
	);

	addr_decode_stage u_decode (
		.clk(clk), .rst_n(rst_n),
		.in_valid(req_head_valid), .in_req(req_head), .pop(req_pop),
		.mem_cfg(mem_cfg),
		.out_valid(dec_valid), .out_dec(dec), .credit_in(link_credit)
	);

	credit_fifo #(.payload_t(bus_pkg::decoded_t), .DEPTH(`BUS_LINK_DEPTH)) link_fifo (
		.clk(clk), .rst_n(rst_n),
		.in_valid(dec_valid), .in_data(dec),
		.out_valid(dec_head_valid), .out_data(dec_head),
		.pop(dec_pop), .credit(link_credit)
	);

	bank_map_stage u_map (
		.clk(clk), .rst_n(rst_n),
		.in_valid(dec_head_valid), .in_dec(dec_head), .pop(dec_pop),
		.rtc(rtc),
		.rsp_valid(rsp_valid), .rsp(rsp), .rsp_credit(rsp_credit)
	);

	// unpack onto plain ports
	assign rsp_region = rsp.region;
	assign rsp_bank   = rsp.bank;
	assign rsp_offset = rsp.offset;
	assign rsp_write  = rsp.write;
	assign rsp_rdata  = rsp.rdata;

endmodule

`default_nettype wire

//--- test/bus_map_properties.sv
// credit protocol checks, bound into bus_map_top
// counts assume the sender never pushes into a full input fifo
`include "bus_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module bus_map_properties (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req_valid,
	input wire logic req_credit,
	input wire logic rsp_valid,
	input wire logic rsp_credit
);

	int rsp_out;         // responses the consumer has not freed yet
	int req_held;        // accepted requests without a credit back
	int fail_count = 0;  // read by the testbench summary

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_out  <= 0;
			req_held <= 0;
		end else begin
			rsp_out  <= rsp_out + int'(rsp_valid) - int'(rsp_credit);
			req_held <= req_held + int'(req_valid) - int'(req_credit);
		end
	end

	//----------------------------------------------------------------------
	rsp_within_credit: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> rsp_out < `BUS_RSP_CREDITS)
	else begin
		$error("response launched without a free output credit");
		fail_count++;
	end

	credit_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		req_credit |-> req_held > 0)  // a credit needs an entry behind it
	else begin
		$error("request credit returned with no accepted request pending");
		fail_count++;
	end

	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !req_credit && !rsp_valid)
	else begin
		$error("req_credit or rsp_valid high during reset");
		fail_count++;
	end

endmodule

bind bus_map_top bus_map_properties u_props (
	.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_credit(req_credit),
	.rsp_valid(rsp_valid), .rsp_credit(rsp_credit)
);

`default_nettype wire

//--- test/bus_map_tb.sv
// testbench for the cpu address path, responses checked against a reference model
// mem_cfg fixed for the whole run, 1 MB chip and 2 slow blocks
`include "bus_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module bus_map_tb;

	localparam int BURST_LEN    = 20;
	localparam int TOTAL_REQS   = 19 + BURST_LEN;     // tests 1 to 4, then the burst
	localparam int WATCHDOG_NS  = TOTAL_REQS * 20 * 8;
	localparam int DRAIN_CYCLES = 100;
	localparam int STALL_CYCLES = 40;

	logic                     clk = 1'b0;
	logic                     rst_n;
	logic                     req_valid;
	logic [`BUS_ADDR_W-1:0]   req_addr;
	logic                     req_write;
	logic [1:0]               req_be;
	logic                     req_credit;
	logic                     rsp_valid;
	bus_pkg::region_t         rsp_region;
	logic [`BUS_BANKS-1:0]    rsp_bank;
	logic [`BUS_OFFSET_W-1:0] rsp_offset;
	logic                     rsp_write;
	logic [3:0]               rsp_rdata;
	logic                     rsp_credit = 1'b0;
	bus_pkg::mem_cfg_t        mem_cfg;
	logic [`BUS_RTC_W-1:0]    rtc;

	int                seed = 67;
	bus_pkg::bus_rsp_t exp_mem [TOTAL_REQS];  // expected, in request order
	int                delay_mem [TOTAL_REQS];  // consumer delay per response
	int                due_mem [TOTAL_REQS];    // credit return cycle
	int                reqs_sent = 0;
	int                credits_back = 0;        // req_credit pulses seen
	int                n_checked = 0;
	int                n_freed = 0;
	int                cyc = 0;
	int                last_due = 0;
	int                mismatches = 0;
	int                lost = 0;
	int                errs_seen = 0;
	logic              overlay_model;
	logic              stall = 1'b0;            // consumer holds its credits
	logic [7:0]        burst_pages [8] = '{8'h00, 8'h08, 8'h18, 8'hbf, 8'hc8, 8'hd0,
		8'hdc, 8'hf8};

	bus_map_top u_dut (.*);

	always #4 clk = ~clk;  // 8 ns

	//----------------------------------------------------------------------
	// reference model, byte address in
	function automatic bus_pkg::bus_rsp_t expect_rsp(input logic [23:0] ba, input logic write);
		bus_pkg::bus_rsp_t r;
		logic [1:0]        blk;
		r        = '0;
		r.offset = ba[18:1];
		r.write  = write;
		if (overlay_model && !write && ba < 24'h080000) begin
			r.region = bus_pkg::region_kick;
		end else if (ba <= 24'h1fffff) begin
			blk = ba[20:19];
			if (blk <= mem_cfg.chip_blocks) begin
				r.region = bus_pkg::region_chip;
				r.bank   = 8'h01 << blk;
			end
		end else if (ba >= 24'hc00000 && ba <= 24'hd7ffff) begin
			blk = 2'((ba - 24'hc00000) >> 19);  // 512 KB steps
			if (blk < mem_cfg.slow_blocks) begin
				r.region = bus_pkg::region_slow;
				r.bank   = 8'h10 << blk;
			end
		end else if (ba[23:16] == 8'hdc) begin
			r.region = bus_pkg::region_rtc;
			if (!write) begin
				r.rdata = 4'(rtc >> (4 * ba[5:2]));
			end
		end else if (ba[23:12] == 12'hdff) begin
			r.region = bus_pkg::region_custom;
		end else if (ba[23:16] == 8'hbf) begin
			if (!ba[12]) begin
				r.region = bus_pkg::region_cia_a;
			end else if (!ba[13]) begin
				r.region = bus_pkg::region_cia_b;
			end
		end else if (ba >= 24'hf80000) begin
			r.region = bus_pkg::region_kick;
		end
		if (r.region == bus_pkg::region_kick) begin
			r.bank = 8'h80;
		end
		return r;
	endfunction

	// waits for a sender credit, then drives one request for one cycle
	task automatic send_req(input logic [23:0] ba, input logic write, input logic [1:0] be);
		bus_pkg::bus_rsp_t exp;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		while (`BUS_REQ_DEPTH + credits_back - reqs_sent == 0) begin
			@(posedge clk);
			#1;
		end
		exp = expect_rsp(ba, write);
		if (exp.region == bus_pkg::region_cia_a && write && be != 2'b00) begin
			overlay_model = 1'b0;  // first cia_a write drops the overlay
		end
		exp_mem[reqs_sent]   = exp;
		delay_mem[reqs_sent] = $unsigned($random(seed)) % 4;
		reqs_sent++;
		req_valid = 1'b1;
		req_addr  = ba[23:1];
		req_write = write;
		req_be    = be;
	endtask

	// idle the bus, wait for all responses, print the test line
	task automatic close_test(input string name);
		int waited;
		int bad;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		waited    = 0;
		while (n_checked < reqs_sent && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (n_checked < reqs_sent) begin
			$display("[%0t] %s: %0d responses never arrived", $time, name, reqs_sent - n_checked);
			lost += reqs_sent - n_checked;
		end
		bad = mismatches + lost - errs_seen;
		$display("%s: %s, %0d errors", name, (bad == 0) ? "pass" : "fail", bad);
		errs_seen = mismatches + lost;
	endtask

	//----------------------------------------------------------------------
	// monitor at the falling edge, outputs settled
	always @(negedge clk) begin
		bus_pkg::bus_rsp_t got;
		int                due;
		if (rst_n && req_credit) begin
			credits_back++;
		end
		if (rst_n && rsp_valid) begin
			got = {rsp_region, rsp_bank, rsp_offset, rsp_write, rsp_rdata};
			if (n_checked >= reqs_sent) begin
				mismatches++;
				$display("[%0t] response arrived with no request outstanding", $time);
			end else begin
				assert (got == exp_mem[n_checked]) else begin
					mismatches++;
					$display("Mismatch at %0t ns: response %0d got %h, expected %h", $time,
						n_checked, got, exp_mem[n_checked]);
				end
				due = cyc + delay_mem[n_checked];
				if (due <= last_due) begin
					due = last_due + 1;  // at most one credit per cycle
				end
				due_mem[n_checked] = due;
				last_due           = due;
				n_checked++;
			end
		end
	end

	// consumer credit return, driven after the rising edge
	always begin
		@(posedge clk);
		#1;
		cyc++;
		if (!stall && n_freed < n_checked && due_mem[n_freed] <= cyc) begin
			n_freed++;
			rsp_credit = 1'b1;
		end else begin
			rsp_credit = 1'b0;
		end
	end

	//----------------------------------------------------------------------
	initial begin
		logic [31:0] r;
		int          total;
		rst_n         = 1'b0;
		req_valid     = 1'b0;
		req_addr      = '0;
		req_write     = 1'b0;
		req_be        = 2'b00;
		overlay_model = 1'b1;
		mem_cfg       = '{chip_blocks: 2'd1, slow_blocks: 2'd2};
		rtc           = {32'($random(seed)), 32'($random(seed))};
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		send_req(24'h000000, 1'b0, 2'b11);  // overlay, kick
		send_req(24'hbfe001, 1'b1, 2'b01);
		send_req(24'h000000, 1'b0, 2'b11);  // chip now
		close_test("test 1 overlay");

		send_req(24'h040000, 1'b0, 2'b11);
		send_req(24'h080000, 1'b0, 2'b11);
		send_req(24'h0ffffe, 1'b0, 2'b11);
		send_req(24'h100000, 1'b0, 2'b11);  // past 1 MB chip
		send_req(24'hc00000, 1'b0, 2'b11);
		send_req(24'hc80000, 1'b1, 2'b10);
		send_req(24'hd00000, 1'b0, 2'b11);  // third slow block, off
		close_test("test 2 memory sizes");

		send_req(24'hbfd000, 1'b0, 2'b11);
		send_req(24'hbff000, 1'b0, 2'b11);
		send_req(24'hdff01e, 1'b1, 2'b11);
		send_req(24'h400000, 1'b0, 2'b11);
		close_test("test 3 register regions");

		send_req(24'hdc0000, 1'b0, 2'b11);
		send_req(24'hdc0014, 1'b0, 2'b11);
		send_req(24'hdc0028, 1'b0, 2'b11);
		send_req(24'hdc003c, 1'b0, 2'b11);
		send_req(24'hdc0004, 1'b1, 2'b11);  // write reads back zero
		close_test("test 4 rtc readout");

		stall = 1'b1;
		fork
			begin
				for (int i = 0; i < BURST_LEN; i++) begin
					r = $random(seed);
					send_req({burst_pages[r[18:16]], r[15:0]}, r[19], r[21:20]);
				end
			end
			begin
				repeat (STALL_CYCLES) @(posedge clk);
				stall = 1'b0;
			end
		join
		close_test("test 5 stalled burst");

		total = mismatches + lost + u_dut.u_props.fail_count;
		$display("summary: %0d responses checked, %0d mismatches, %0d lost, %0d assertion failures",
			n_checked, mismatches, lost, u_dut.u_props.fail_count);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// run limit from the request count
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/bus_pkg.sv
design/credit_fifo.sv
design/addr_decode_stage.sv
design/bank_map_stage.sv
design/bus_map_top.sv
test/bus_map_properties.sv
test/bus_map_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bus map testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f sources.f --top-module bus_map_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vbus_map_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
